// ==== hudPkg.sv ====
`default_nettype none

package hudPkg;

	localparam int TicksPerSecond = 40; // Short second so simulation stays quick
	localparam logic [7:0] StartTime = 8'h60; // Two BCD digits

	localparam int CoordWidth = 11;

	localparam logic [CoordWidth-1:0] BarWidth = 11'd640;
	localparam logic [CoordWidth-1:0] BarHeight = 11'd48;

	localparam logic [CoordWidth-1:0] DigitWidth = 11'd16;
	localparam logic [CoordWidth-1:0] DigitHeight = 11'd32;
	localparam logic [CoordWidth-1:0] DigitTopY = 11'd8;
	localparam logic [CoordWidth-1:0] TensDigitX = 11'd304; // Ones digit follows one box later

	localparam logic [CoordWidth-1:0] HeartSize = 11'd32;
	localparam logic [CoordWidth-1:0] HeartTopY = 11'd8;
	localparam logic [CoordWidth-1:0] HeartX0 = 11'd16;
	localparam logic [CoordWidth-1:0] HeartPitch = 11'd48;

	// RGB332 colours
	localparam logic [7:0] DigitColor = 8'hFF;
	localparam logic [7:0] HeartColor = 8'hE0;
	localparam logic [7:0] BackgroundColor = 8'h49;

endpackage

`default_nettype wire

// ==== oneSecCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module oneSecCounter (
	input logic clk,
	input logic resetN,
	output logic oneSec,
	output logic duty50
);

	logic [31:0] count;
	logic [31:0] nextCount;

	assign nextCount = (count == hudPkg::TicksPerSecond - 1) ? '0 : count + 32'd1;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			count <= '0;
			oneSec <= 1'b0;
			duty50 <= 1'b0;
		end else begin
			count <= nextCount;
			oneSec <= (nextCount == '0); // Pulse on the wrap
			duty50 <= (nextCount < hudPkg::TicksPerSecond / 2); // High in the lower half of the count
		end
	end

	noDoublePulse: assert property (@(posedge clk) disable iff (!resetN)
		oneSec |=> !oneSec);

endmodule

`default_nettype wire

// ==== timerCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module timerCounter (
	input logic clk,
	input logic resetN,
	input logic oneSec,
	input logic timerLoad,
	input logic [1:0][3:0] timeToAdd,
	output logic [1:0][3:0] timerDigits,
	output logic outOfTime
);

	logic running;
	logic [4:0] onesSum;
	logic [4:0] tensSum;
	logic [1:0][3:0] addResult;
	logic [1:0][3:0] decResult;
	logic [1:0][3:0] nextDigits;

	always_comb begin
		onesSum = {1'b0, timerDigits[0]} + {1'b0, timeToAdd[0]};
		tensSum = {1'b0, timerDigits[1]} + {1'b0, timeToAdd[1]};
		if (onesSum > 5'd9) begin
			onesSum = onesSum - 5'd10; // Decimal carry into the tens
			tensSum = tensSum + 5'd1;
		end
		if (tensSum > 5'd9)
			addResult = {4'd9, 4'd9}; // Saturate at 99
		else
			addResult = {tensSum[3:0], onesSum[3:0]};
	end

	always_comb begin
		if (timerDigits[0] == 4'd0)
			decResult = {timerDigits[1] - 4'd1, 4'd9}; // Borrow from the tens
		else
			decResult = {timerDigits[1], timerDigits[0] - 4'd1};
	end

	always_comb begin
		nextDigits = timerDigits;
		if (timerLoad)
			nextDigits = addResult; // Load wins over a tick
		else if (oneSec && running && (timerDigits != '0))
			nextDigits = decResult;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			timerDigits <= hudPkg::StartTime;
			outOfTime <= 1'b0;
			running <= 1'b1;
		end else begin
			timerDigits <= nextDigits;
			outOfTime <= (nextDigits == '0);
			if (timerLoad)
				running <= 1'b1;
			else if (outOfTime)
				running <= 1'b0;
		end
	end

	digitsAreBcd: assert property (@(posedge clk) disable iff (!resetN)
		(timerDigits[1] <= 4'd9) && (timerDigits[0] <= 4'd9));

	zeroWhenOut: assert property (@(posedge clk) disable iff (!resetN)
		outOfTime && !timerLoad |=> (timerDigits == '0));

endmodule

`default_nettype wire

// ==== squareObject.sv ====
`timescale 1ns/1ps
`default_nettype none

module squareObject (
	input logic clk,
	input logic resetN,
	input logic [hudPkg::CoordWidth-1:0] pixelX,
	input logic [hudPkg::CoordWidth-1:0] pixelY,
	input logic [hudPkg::CoordWidth-1:0] topLeftX,
	input logic [hudPkg::CoordWidth-1:0] topLeftY,
	input logic [hudPkg::CoordWidth-1:0] width,
	input logic [hudPkg::CoordWidth-1:0] height,
	output logic insideRect,
	output logic [hudPkg::CoordWidth-1:0] offsetX,
	output logic [hudPkg::CoordWidth-1:0] offsetY
);

	logic hitX;
	logic hitY;

	assign hitX = (pixelX >= topLeftX) && (pixelX < topLeftX + width);
	assign hitY = (pixelY >= topLeftY) && (pixelY < topLeftY + height);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			insideRect <= 1'b0;
		else
			insideRect <= hitX && hitY;
	end

	always_ff @(posedge clk) begin
		offsetX <= pixelX - topLeftX; // Only meaningful while inside
		offsetY <= pixelY - topLeftY;
	end

endmodule

`default_nettype wire

// ==== digitBitmap.sv ====
`timescale 1ns/1ps
`default_nettype none

module digitBitmap (
	input logic clk,
	input logic resetN,
	input logic [hudPkg::CoordWidth-1:0] offsetX,
	input logic [hudPkg::CoordWidth-1:0] offsetY,
	input logic insideRect,
	input logic [3:0] digit,
	output logic drawRequest,
	output logic [7:0] digitRGB
);

	logic [6:0] segMask; // Segments a to g, a in the top bit
	logic [6:0] segHit;
	logic horizCols;
	logic leftCol;
	logic rightCol;
	logic upperHalf;

	always_comb begin
		case (digit)
			4'd0: segMask = 7'b1111110;
			4'd1: segMask = 7'b0110000;
			4'd2: segMask = 7'b1101101;
			4'd3: segMask = 7'b1111001;
			4'd4: segMask = 7'b0110011;
			4'd5: segMask = 7'b1011011;
			4'd6: segMask = 7'b1011111;
			4'd7: segMask = 7'b1110000;
			4'd8: segMask = 7'b1111111;
			4'd9: segMask = 7'b1111011;
			default: segMask = 7'b0000000; // Blank for non-BCD codes
		endcase
	end

	assign horizCols = (offsetX >= 11'd2) && (offsetX < hudPkg::DigitWidth - 11'd2);
	assign leftCol = (offsetX < 11'd4);
	assign rightCol = (offsetX >= hudPkg::DigitWidth - 11'd4);
	assign upperHalf = (offsetY < hudPkg::DigitHeight / 11'd2);

	assign segHit[6] = horizCols && (offsetY < 11'd4);
	assign segHit[5] = rightCol && upperHalf;
	assign segHit[4] = rightCol && !upperHalf;
	assign segHit[3] = horizCols && (offsetY >= hudPkg::DigitHeight - 11'd4);
	assign segHit[2] = leftCol && !upperHalf;
	assign segHit[1] = leftCol && upperHalf;
	assign segHit[0] = horizCols && (offsetY >= hudPkg::DigitHeight / 11'd2 - 11'd2)
		&& (offsetY < hudPkg::DigitHeight / 11'd2 + 11'd2); // Middle bar straddles the centre

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			drawRequest <= 1'b0;
		else
			drawRequest <= insideRect && (|(segMask & segHit));
	end

	assign digitRGB = hudPkg::DigitColor;

endmodule

`default_nettype wire

// ==== heartDraw.sv ====
`timescale 1ns/1ps
`default_nettype none

module heartDraw (
	input logic clk,
	input logic resetN,
	input logic [hudPkg::CoordWidth-1:0] offsetX,
	input logic [hudPkg::CoordWidth-1:0] offsetY,
	input logic insideRect,
	input logic isActive,
	output logic drawRequest,
	output logic [7:0] heartRGB
);

	logic [31:0] rowBits; // Column 0 sits in the top bit

	always_comb begin
		case (offsetY[4:0])
			5'd2: rowBits = 32'h03C003C0;
			5'd3: rowBits = 32'h0FF00FF0;
			5'd4: rowBits = 32'h1FF81FF8;
			5'd5: rowBits = 32'h3FFC3FFC;
			5'd6: rowBits = 32'h3FFE7FFC;
			5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13: rowBits = 32'h7FFFFFFE;
			5'd14, 5'd15: rowBits = 32'h3FFFFFFC;
			5'd16, 5'd17: rowBits = 32'h1FFFFFF8;
			5'd18: rowBits = 32'h0FFFFFF0;
			5'd19: rowBits = 32'h07FFFFE0;
			5'd20: rowBits = 32'h03FFFFC0;
			5'd21: rowBits = 32'h01FFFF80;
			5'd22: rowBits = 32'h00FFFF00;
			5'd23: rowBits = 32'h007FFE00;
			5'd24: rowBits = 32'h003FFC00;
			5'd25: rowBits = 32'h001FF800;
			5'd26: rowBits = 32'h000FF000;
			5'd27: rowBits = 32'h0007E000;
			5'd28: rowBits = 32'h0003C000;
			5'd29: rowBits = 32'h00018000; // Tip of the heart
			default: rowBits = 32'h00000000;
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			drawRequest <= 1'b0;
		else
			drawRequest <= insideRect && isActive && rowBits[5'd31 - offsetX[4:0]];
	end

	assign heartRGB = hudPkg::HeartColor;

endmodule

`default_nettype wire

// ==== topBarMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module topBarMux (
	input logic clk,
	input logic resetN,
	input logic [1:0] digitRequest,
	input logic [1:0][7:0] digitRGB,
	input logic [2:0] heartRequest,
	input logic [2:0][7:0] heartRGB,
	input logic backgroundInside,
	output logic barDrawingRequest,
	output logic [7:0] barRGB
);

	logic bgInside; // Background flag aligned with the renderer stage
	logic nextRequest;
	logic [7:0] nextRGB;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			bgInside <= 1'b0;
		else
			bgInside <= backgroundInside;
	end

	always_comb begin
		nextRequest = 1'b1;
		nextRGB = 8'h00;
		if (digitRequest[1])
			nextRGB = digitRGB[1];
		else if (digitRequest[0])
			nextRGB = digitRGB[0];
		else if (heartRequest[0])
			nextRGB = heartRGB[0];
		else if (heartRequest[1])
			nextRGB = heartRGB[1];
		else if (heartRequest[2])
			nextRGB = heartRGB[2];
		else if (bgInside)
			nextRGB = hudPkg::BackgroundColor;
		else
			nextRequest = 1'b0; // Outside the bar
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			barDrawingRequest <= 1'b0;
			barRGB <= 8'h00;
		end else begin
			barDrawingRequest <= nextRequest;
			barRGB <= nextRGB;
		end
	end

endmodule

`default_nettype wire

// ==== topBar.sv ====
`timescale 1ns/1ps
`default_nettype none

module topBar (
	input logic clk,
	input logic resetN,
	input logic [hudPkg::CoordWidth-1:0] pixelX,
	input logic [hudPkg::CoordWidth-1:0] pixelY,
	input logic timerLoad,
	input logic [1:0][3:0] timeToAdd,
	input logic [1:0] numHearts,
	output logic [1:0][3:0] timerDigits,
	output logic oneSec,
	output logic duty50,
	output logic outOfTime,
	output logic barDrawingRequest,
	output logic [7:0] barRGB
);

	logic [hudPkg::CoordWidth-1:0] onesDigitX;
	logic [2:0][hudPkg::CoordWidth-1:0] heartX;
	logic [1:0] digitInside;
	logic [1:0][hudPkg::CoordWidth-1:0] digitOffX;
	logic [1:0][hudPkg::CoordWidth-1:0] digitOffY;
	logic [1:0] digitRequest;
	logic [1:0][7:0] digitRGB;
	logic [2:0] heartInside;
	logic [2:0][hudPkg::CoordWidth-1:0] heartOffX;
	logic [2:0][hudPkg::CoordWidth-1:0] heartOffY;
	logic [2:0] heartRequest;
	logic [2:0][7:0] heartRGB;
	logic bgInside;

	assign onesDigitX = hudPkg::TensDigitX + hudPkg::DigitWidth;
	assign heartX[0] = hudPkg::HeartX0;
	assign heartX[1] = hudPkg::HeartX0 + hudPkg::HeartPitch;
	assign heartX[2] = hudPkg::HeartX0 + hudPkg::HeartPitch + hudPkg::HeartPitch;

	oneSecCounter oneSecCounter_inst (
		.clk(clk),
		.resetN(resetN),
		.oneSec(oneSec),
		.duty50(duty50)
	);

	timerCounter timerCounter_inst (
		.clk(clk),
		.resetN(resetN),
		.oneSec(oneSec),
		.timerLoad(timerLoad),
		.timeToAdd(timeToAdd),
		.timerDigits(timerDigits),
		.outOfTime(outOfTime)
	);

	// Index 0 is the ones digit, index 1 the tens digit
	for (genvar i = 0; i < 2; i++) begin : genDigit
		squareObject digitSquare (
			.clk(clk),
			.resetN(resetN),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.topLeftX(i == 0 ? onesDigitX : hudPkg::TensDigitX),
			.topLeftY(hudPkg::DigitTopY),
			.width(hudPkg::DigitWidth),
			.height(hudPkg::DigitHeight),
			.insideRect(digitInside[i]),
			.offsetX(digitOffX[i]),
			.offsetY(digitOffY[i])
		);

		digitBitmap digitDraw (
			.clk(clk),
			.resetN(resetN),
			.offsetX(digitOffX[i]),
			.offsetY(digitOffY[i]),
			.insideRect(digitInside[i]),
			.digit(timerDigits[i]),
			.drawRequest(digitRequest[i]),
			.digitRGB(digitRGB[i])
		);
	end

	for (genvar i = 0; i < 3; i++) begin : genHeart
		squareObject heartSquare (
			.clk(clk),
			.resetN(resetN),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.topLeftX(heartX[i]),
			.topLeftY(hudPkg::HeartTopY),
			.width(hudPkg::HeartSize),
			.height(hudPkg::HeartSize),
			.insideRect(heartInside[i]),
			.offsetX(heartOffX[i]),
			.offsetY(heartOffY[i])
		);

		heartDraw heartDraw_inst (
			.clk(clk),
			.resetN(resetN),
			.offsetX(heartOffX[i]),
			.offsetY(heartOffY[i]),
			.insideRect(heartInside[i]),
			.isActive(numHearts > 2'(i)), // Heart i shows while lives exceed i
			.drawRequest(heartRequest[i]),
			.heartRGB(heartRGB[i])
		);
	end

	squareObject bgSquare (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.topLeftX('0),
		.topLeftY('0),
		.width(hudPkg::BarWidth),
		.height(hudPkg::BarHeight),
		.insideRect(bgInside),
		.offsetX(),
		.offsetY()
	);

	topBarMux topBarMux_inst (
		.clk(clk),
		.resetN(resetN),
		.digitRequest(digitRequest),
		.digitRGB(digitRGB),
		.heartRequest(heartRequest),
		.heartRGB(heartRGB),
		.backgroundInside(bgInside),
		.barDrawingRequest(barDrawingRequest),
		.barRGB(barRGB)
	);

endmodule

`default_nettype wire

// ==== topBarTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module topBarTb;

	localparam int FieldsPerLine = 5;
	localparam int MaxLines = 40;
	localparam logic [11:0] OpPixel = 12'h001;
	localparam logic [11:0] OpLoad = 12'h002;
	localparam logic [11:0] OpWaitSec = 12'h003;
	localparam logic [11:0] OpHearts = 12'h004;
	localparam logic [11:0] OpEnd = 12'h0FF;
	localparam int PulseTimeout = hudPkg::TicksPerSecond + 8;

	logic clk;
	logic resetN;
	logic [hudPkg::CoordWidth-1:0] pixelX;
	logic [hudPkg::CoordWidth-1:0] pixelY;
	logic timerLoad;
	logic [1:0][3:0] timeToAdd;
	logic [1:0] numHearts;
	logic [1:0][3:0] timerDigits;
	logic oneSec;
	logic duty50;
	logic outOfTime;
	logic barDrawingRequest;
	logic [7:0] barRGB;

	logic [11:0] patterns [0:FieldsPerLine*MaxLines-1];
	int checks;
	int mismatches;
	int otherErrors;

	topBar topBar_inst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.timerLoad(timerLoad),
		.timeToAdd(timeToAdd),
		.numHearts(numHearts),
		.timerDigits(timerDigits),
		.oneSec(oneSec),
		.duty50(duty50),
		.outOfTime(outOfTime),
		.barDrawingRequest(barDrawingRequest),
		.barRGB(barRGB)
	);

	always #50 clk = ~clk;

	// Inputs change and outputs are read 5 ns after each rising edge
	task automatic nextCycle();
		@(posedge clk);
		#5;
	endtask

	task automatic checkDigits(input string name, input logic [1:0][3:0] expected,
			input logic [1:0][3:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			mismatches++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkPixel(input string name, input logic expRequest, input logic [7:0] expRGB,
			input logic actRequest, input logic [7:0] actRGB);
		checks++;
		if (actRequest !== expRequest || actRGB !== expRGB) begin
			mismatches++;
			$display("mismatch %s: expected %b/%h, actual %b/%h", name, expRequest, expRGB,
				actRequest, actRGB);
		end
	endtask

	// Returns at the sample where oneSec is high
	task automatic waitPulse(input string name);
		int cycles;
		cycles = 0;
		nextCycle();
		while (oneSec !== 1'b1 && cycles < PulseTimeout) begin
			nextCycle();
			cycles++;
		end
		if (oneSec !== 1'b1) begin
			otherErrors++;
			$display("timeout in %s: no oneSec pulse within %0d cycles", name, PulseTimeout);
		end
	endtask

	task automatic checkReset();
		int cycles;
		checkDigits("reset timerDigits", hudPkg::StartTime, timerDigits);
		checkBit("reset outOfTime", 1'b0, outOfTime);
		checkBit("reset oneSec", 1'b0, oneSec);
		checkBit("reset barDrawingRequest", 1'b0, barDrawingRequest);
		cycles = 0;
		while (oneSec !== 1'b1 && cycles < PulseTimeout) begin
			nextCycle();
			cycles++;
		end
		if (oneSec !== 1'b1) begin
			otherErrors++;
			$display("timeout after reset: the first oneSec pulse never came");
			return;
		end
		checkCount("first oneSec latency", hudPkg::TicksPerSecond, cycles);
		nextCycle();
		checkDigits("borrow 60 to 59", 8'h59, timerDigits);
	endtask

	task automatic applyPixel(input string name, input logic [hudPkg::CoordWidth-1:0] x,
			input logic [hudPkg::CoordWidth-1:0] y, input logic expRequest,
			input logic [7:0] expRGB);
		pixelX = x;
		pixelY = y;
		repeat (3) nextCycle(); // Three register stages to the bar output
		checkPixel($sformatf("%s pixel (%0d,%0d)", name, x, y), expRequest, expRGB,
			barDrawingRequest, barRGB);
	endtask

	task automatic applyLoad(input string name, input logic [1:0][3:0] addend,
			input logic [1:0][3:0] expDigits, input logic expOut);
		timerLoad = 1'b1;
		timeToAdd = addend;
		nextCycle();
		timerLoad = 1'b0;
		timeToAdd = '0;
		checkDigits({name, " load timerDigits"}, expDigits, timerDigits);
		checkBit({name, " load outOfTime"}, expOut, outOfTime);
	endtask

	task automatic waitSeconds(input string name, input int seconds,
			input logic [1:0][3:0] expDigits, input logic expOut);
		int s;
		for (s = 0; s < seconds; s++) begin
			waitPulse(name);
			if (otherErrors != 0)
				return;
		end
		nextCycle(); // The timer updates one cycle after the pulse
		checkDigits({name, " timerDigits"}, expDigits, timerDigits);
		checkBit({name, " outOfTime"}, expOut, outOfTime);
	endtask

	task automatic runPatterns();
		int line;
		logic [7:0] base;
		logic [11:0] op;
		logic [11:0] argA;
		logic [11:0] argB;
		logic [11:0] expA;
		logic [11:0] expB;
		string name;
		line = 0;
		while (line < MaxLines && otherErrors == 0) begin
			base = 8'(line * FieldsPerLine);
			op = patterns[base];
			argA = patterns[base + 8'd1];
			argB = patterns[base + 8'd2];
			expA = patterns[base + 8'd3];
			expB = patterns[base + 8'd4];
			name = $sformatf("pattern %0d", line + 1);
			if (op == OpEnd)
				break;
			case (op)
				OpPixel: applyPixel(name, argA[hudPkg::CoordWidth-1:0],
					argB[hudPkg::CoordWidth-1:0], expA[0], expB[7:0]);
				OpLoad: applyLoad(name, argA[7:0], expA[7:0], expB[0]);
				OpWaitSec: waitSeconds(name, int'(argA), expA[7:0], expB[0]);
				OpHearts: begin
					numHearts = argA[1:0];
					nextCycle();
				end
				default: begin
					otherErrors++;
					$display("unknown opcode %h in %s of the patterns file", op, name);
				end
			endcase
			line++;
		end
	endtask

	// duty50 is high for the first half of the period that starts with a pulse
	task automatic checkPeriod();
		int k;
		waitPulse("period check");
		if (otherErrors != 0)
			return;
		for (k = 0; k < hudPkg::TicksPerSecond; k++) begin
			checkBit($sformatf("duty50 cycle %0d", k), k < hudPkg::TicksPerSecond / 2, duty50);
			if (k > 0)
				checkBit($sformatf("oneSec cycle %0d", k), 1'b0, oneSec);
			nextCycle();
		end
		checkBit("oneSec after one period", 1'b1, oneSec);
	endtask

	initial begin
		clk = 1'b0;
		resetN = 1'b0;
		pixelX = '0;
		pixelY = '1; // Well below the bar
		timerLoad = 1'b0;
		timeToAdd = '0;
		numHearts = 2'd0;
		checks = 0;
		mismatches = 0;
		otherErrors = 0;
		$readmemh("topBarPatterns.txt", patterns);
		repeat (16) nextCycle();
		resetN = 1'b1;
		checkReset();
		if (otherErrors == 0)
			runPatterns();
		if (otherErrors == 0)
			checkPeriod();
		$display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== topBarPatterns.txt ====
// Columns in hex: opcode argA argB expA expB
// 001 PIXEL x y request rgb, 002 LOAD addend 000 digits outOfTime
// 003 WAITSEC seconds 000 digits outOfTime, 004 HEARTS count, 0FF end
002 007 000 066 000
001 136 009 001 0FF // Tens digit segment a
001 13E 010 001 049 // Tens digit segment b is dark for 6
001 146 017 001 0FF // Ones digit segment g
001 141 020 001 0FF // Ones digit segment e
001 148 010 001 049 // Inside the ones box between segments
001 064 030 000 000 // Row 48 is below the bar
003 010 000 050 000
003 001 000 049 000
003 02F 000 002 000
003 001 000 001 000
003 001 000 000 001
003 002 000 000 001
002 095 000 095 000
002 020 000 099 000
003 001 000 098 000
004 000 000 000 000
001 020 012 001 049
004 001 000 000 000
001 020 012 001 0E0
001 050 012 001 049
004 002 000 000 000
001 050 012 001 0E0
001 080 012 001 049
004 003 000 000 000
001 080 012 001 0E0
001 020 00A 001 049 // Notch between the two lobes of heart 0
0FF 000 000 000 000

// ==== sim.f ====
hudPkg.sv
oneSecCounter.sv
timerCounter.sv
squareObject.sv
digitBitmap.sv
heartDraw.sv
topBarMux.sv
topBar.sv
topBarTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = topBarTb
RTL_TOP  = topBar
FILELIST = sim.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
